// File: common/comp_defines.svh
`ifndef COMP_DEFINES_SVH
`define COMP_DEFINES_SVH

// Stream word width in bits
`define COMP_DATA_W 32

// Packet header layout
`define COMP_HDR_WORDS    8
`define COMP_HDR_FLAG_IDX 4
`define COMP_HDR_LEN_IDX  5
`define COMP_HDR_TASK_IDX 6

// Completion trailer appended after the payload
`define COMP_TRL_WORDS 4

`define COMP_FIFO_DEPTH 4

// Value returned by the identity register
`define COMP_ID_WORD 32'h1006_0402

`endif

// File: common/comp_stream_pkg.sv
`default_nettype none
`include "comp_defines.svh"

package comp_stream_pkg;

   typedef logic [`COMP_DATA_W-1:0] word_t;

   // 0 all bytes valid, 1 upper three, 3 upper two, 7 upper one
   typedef logic [3:0]  rem_t;
   typedef logic [2:0]  flags_t;
   typedef logic [31:0] len_t;      // Byte count
   typedef logic [9:0]  task_idx_t;
   typedef logic [2:0]  hdr_cnt_t;

   typedef enum logic [1:0] {
      ING_IDLE,
      ING_HEADER,
      ING_PAYLOAD,
      ING_INFO_WAIT
   } ingress_state_e;

   typedef enum logic [1:0] {
      EGR_INFO_WAIT,
      EGR_PAYLOAD,
      EGR_TRAILER
   } egress_state_e;

endpackage

`default_nettype wire

// File: common/comp_csr_pkg.sv
`default_nettype none

package comp_csr_pkg;

   typedef logic [3:0]  csr_addr_t;
   typedef logic [31:0] csr_data_t;
   typedef logic [15:0] pkt_cnt_t;

   // Register map
   localparam csr_addr_t CSR_CTRL     = 4'd0;  // Bit 0 soft reset, write only
   localparam csr_addr_t CSR_ID       = 4'd1;
   localparam csr_addr_t CSR_PKT_CNT  = 4'd2;
   localparam csr_addr_t CSR_LAST_LEN = 4'd3;

endpackage

`default_nettype wire

// File: engine/pkt_ingress.sv
`timescale 1ns/1ps
`default_nettype none
`include "comp_defines.svh"

module pkt_ingress (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       soft_rst_i,
   input  wire logic                       in_valid_i,
   input  wire comp_stream_pkg::word_t     in_data_i,
   input  wire comp_stream_pkg::rem_t      in_rem_i,
   input  wire logic                       in_last_i,
   output logic                            in_ready_o,
   output logic                            push_valid_o,
   output comp_stream_pkg::word_t          push_data_o,
   output comp_stream_pkg::rem_t           push_rem_o,
   output logic                            push_last_o,
   input  wire logic                       push_ready_i,
   output logic                            info_valid_o,
   output comp_stream_pkg::flags_t         info_flags_o,
   output comp_stream_pkg::len_t           info_len_o,
   output comp_stream_pkg::task_idx_t      info_task_o,
   input  wire logic                       info_ready_i
);
   import comp_stream_pkg::*;

   ingress_state_e state;
   hdr_cnt_t       hdr_cnt;   // Index of the header word being accepted
   flags_t         flags_q;
   len_t           len_q;
   task_idx_t      task_q;
   logic           in_xfer;

   // Zero the bytes that the remainder code marks unused
   function automatic word_t mask_last(word_t d, rem_t r);
      word_t m;
      case (r)
         4'h1:    m = {d[31:8], 8'h0};
         4'h3:    m = {d[31:16], 16'h0};
         4'h7:    m = {d[31:24], 24'h0};
         default: m = d;
      endcase
      return m;
   endfunction

   always_comb begin
      case (state)
         ING_PAYLOAD:   in_ready_o = push_ready_i;
         ING_INFO_WAIT: in_ready_o = 1'b0;  // Hold off next packet
         default:       in_ready_o = 1'b1;
      endcase
   end

   assign in_xfer      = in_valid_i && in_ready_o;
   assign push_valid_o = (state == ING_PAYLOAD) && in_valid_i;
   assign push_data_o  = in_last_i ? mask_last(in_data_i, in_rem_i) : in_data_i;
   assign push_rem_o   = in_rem_i;
   assign push_last_o  = in_last_i;

   assign info_valid_o = (state == ING_INFO_WAIT);
   assign info_flags_o = flags_q;
   assign info_len_o   = len_q;
   assign info_task_o  = task_q;

   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         state   <= ING_IDLE;
         hdr_cnt <= '0;
      end else begin
         case (state)
            ING_IDLE: if (in_xfer) begin
               state   <= ING_HEADER;  // Word 0 taken here
               hdr_cnt <= hdr_cnt_t'(1);
            end
            ING_HEADER: if (in_xfer) begin
               hdr_cnt <= hdr_cnt + hdr_cnt_t'(1);
               if (hdr_cnt == hdr_cnt_t'(`COMP_HDR_WORDS - 1))
                  state <= ING_PAYLOAD;
            end
            ING_PAYLOAD: if (in_xfer && in_last_i) state <= ING_INFO_WAIT;
            ING_INFO_WAIT: if (info_ready_i) state <= ING_IDLE;
            default: state <= ING_IDLE;
         endcase
      end
   end

   // Header fields
   always_ff @(posedge clk) begin
      if (state == ING_HEADER && in_xfer) begin
         if (hdr_cnt == hdr_cnt_t'(`COMP_HDR_FLAG_IDX)) flags_q <= in_data_i[31:29];
         if (hdr_cnt == hdr_cnt_t'(`COMP_HDR_LEN_IDX))  len_q   <= in_data_i;
         if (hdr_cnt == hdr_cnt_t'(`COMP_HDR_TASK_IDX)) task_q  <= in_data_i[9:0];
      end
   end

   // Payload only once every header word has been counted
   a_no_push_in_header: assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
      push_valid_o |-> hdr_cnt == hdr_cnt_t'(`COMP_HDR_WORDS));

endmodule

`default_nettype wire

// File: engine/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "comp_defines.svh"

module payload_fifo #(
   parameter int DEPTH = `COMP_FIFO_DEPTH
) (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       soft_rst_i,
   input  wire logic                       push_valid_i,
   input  wire comp_stream_pkg::word_t     push_data_i,
   input  wire comp_stream_pkg::rem_t      push_rem_i,
   input  wire logic                       push_last_i,
   output logic                            push_ready_o,
   output logic                            pop_valid_o,
   output comp_stream_pkg::word_t          pop_data_o,
   output comp_stream_pkg::rem_t           pop_rem_o,
   output logic                            pop_last_o,
   input  wire logic                       pop_ready_i
);
   import comp_stream_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   word_t          data_mem [DEPTH];
   rem_t           rem_mem  [DEPTH];
   logic [DEPTH-1:0] last_mem;
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [CW-1:0]  count;
   logic           push;
   logic           pop;

   assign push_ready_o = (count != CW'(DEPTH));
   assign pop_valid_o  = (count != '0);
   assign push         = push_valid_i && push_ready_o;
   assign pop          = pop_valid_o && pop_ready_i;

   assign pop_data_o = data_mem[rd_ptr];
   assign pop_rem_o  = rem_mem[rd_ptr];
   assign pop_last_o = last_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
         if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
         count <= count + CW'(push) - CW'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr] <= push_data_i;
         rem_mem[wr_ptr]  <= push_rem_i;
         last_mem[wr_ptr] <= push_last_i;
      end
   end

   // A wrapped count would show up above DEPTH
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
      count <= CW'(DEPTH));
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
      count == '0 |-> wr_ptr == rd_ptr);

endmodule

`default_nettype wire

// File: engine/pkt_egress.sv
`timescale 1ns/1ps
`default_nettype none
`include "comp_defines.svh"

module pkt_egress (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       soft_rst_i,
   input  wire logic                       info_valid_i,
   input  wire comp_stream_pkg::flags_t    info_flags_i,
   input  wire comp_stream_pkg::len_t      info_len_i,
   input  wire comp_stream_pkg::task_idx_t info_task_i,
   output logic                            info_ready_o,
   input  wire logic                       pop_valid_i,
   input  wire comp_stream_pkg::word_t     pop_data_i,
   input  wire comp_stream_pkg::rem_t      pop_rem_i,
   input  wire logic                       pop_last_i,
   output logic                            pop_ready_o,
   output logic                            out_valid_o,
   output comp_stream_pkg::word_t          out_data_o,
   output logic                            out_last_o,
   input  wire logic                       out_ready_i,
   output logic                            pkt_done_o,
   output comp_stream_pkg::len_t           pkt_bytes_o
);
   import comp_stream_pkg::*;

   localparam int TRL_W = $clog2(`COMP_TRL_WORDS);

   egress_state_e    state;
   logic [TRL_W-1:0] trl_cnt;
   len_t             byte_cnt;   // Running total of the current payload
   len_t             trl_bytes;  // Total frozen for the trailer
   flags_t           flags_q;
   task_idx_t        task_q;
   logic             status_q;
   logic             out_free;
   logic             pop_xfer;
   logic             info_xfer;
   logic             trl_last;
   word_t            trl_word;

   function automatic len_t rem_bytes(rem_t r);
      case (r)
         4'h1:    return len_t'(3);
         4'h3:    return len_t'(2);
         4'h7:    return len_t'(1);
         default: return len_t'(`COMP_DATA_W / 8);
      endcase
   endfunction

   assign out_free     = !out_valid_o || out_ready_i;
   assign pop_ready_o  = (state == EGR_PAYLOAD) && out_free;
   assign pop_xfer     = pop_valid_i && pop_ready_o;
   assign info_ready_o = (state == EGR_INFO_WAIT);
   assign info_xfer    = info_valid_i && info_ready_o;
   assign trl_last     = (trl_cnt == TRL_W'(`COMP_TRL_WORDS - 1));
   assign pkt_done_o   = out_valid_o && out_ready_i && out_last_o;
   assign pkt_bytes_o  = trl_bytes;

   always_comb begin
      case (trl_cnt)
         2'd0:    trl_word = {flags_q, status_q, 28'h0};
         2'd1:    trl_word = trl_bytes;
         2'd2:    trl_word = {22'h0, task_q};
         default: trl_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         state       <= EGR_PAYLOAD;
         trl_cnt     <= '0;
         byte_cnt    <= '0;
         out_valid_o <= 1'b0;
         out_last_o  <= 1'b0;
      end else begin
         if (out_free) begin
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
         end
         case (state)
            EGR_PAYLOAD: if (pop_xfer) begin
               out_valid_o <= 1'b1;
               byte_cnt    <= byte_cnt + (pop_last_i ? rem_bytes(pop_rem_i)
                                                     : len_t'(`COMP_DATA_W / 8));
               if (pop_last_i) state <= EGR_INFO_WAIT;
            end
            EGR_INFO_WAIT: if (info_xfer) begin
               state    <= EGR_TRAILER;
               trl_cnt  <= '0;
               byte_cnt <= '0;
            end
            EGR_TRAILER: if (out_free) begin
               out_valid_o <= 1'b1;
               out_last_o  <= trl_last;
               trl_cnt     <= trl_cnt + TRL_W'(1);
               if (trl_last) state <= EGR_PAYLOAD;
            end
            default: state <= EGR_PAYLOAD;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop_xfer) out_data_o <= pop_data_i;
      else if (state == EGR_TRAILER && out_free) out_data_o <= trl_word;
      if (info_xfer) begin
         flags_q   <= info_flags_i;
         task_q    <= info_task_i;
         trl_bytes <= byte_cnt;
         status_q  <= (byte_cnt == info_len_i);  // Counted total matches header
      end
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n || soft_rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) && $stable(out_last_o));

endmodule

`default_nettype wire

// File: verilog/comp_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "comp_defines.svh"

module comp_csr (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       csr_rd_i,
   input  wire logic                       csr_wr_i,
   input  wire comp_csr_pkg::csr_addr_t    csr_addr_i,
   input  wire comp_csr_pkg::csr_data_t    csr_wdata_i,
   output comp_csr_pkg::csr_data_t         csr_rdata_o,
   output logic                            csr_ack_o,
   input  wire logic                       pkt_done_i,
   input  wire comp_stream_pkg::len_t      pkt_bytes_i,
   output logic                            soft_rst_o
);
   import comp_stream_pkg::*;
   import comp_csr_pkg::*;

   pkt_cnt_t  pkt_cnt;
   len_t      last_len;
   csr_data_t rd_mux;

   always_comb begin
      case (csr_addr_i)
         CSR_ID:       rd_mux = `COMP_ID_WORD;
         CSR_PKT_CNT:  rd_mux = csr_data_t'(pkt_cnt);
         CSR_LAST_LEN: rd_mux = last_len;
         default:      rd_mux = '0;  // CTRL and unmapped
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_ack_o  <= 1'b0;
         soft_rst_o <= 1'b0;
      end else begin
         csr_ack_o  <= csr_rd_i || csr_wr_i;
         soft_rst_o <= csr_wr_i && (csr_addr_i == CSR_CTRL) && csr_wdata_i[0];
      end
   end

   always_ff @(posedge clk) begin
      if (csr_rd_i) csr_rdata_o <= rd_mux;
   end

   // Statistics, also cleared by soft reset
   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_o) begin
         pkt_cnt  <= '0;
         last_len <= '0;
      end else if (pkt_done_i) begin
         pkt_cnt  <= pkt_cnt + pkt_cnt_t'(1);
         last_len <= pkt_bytes_i;
      end
   end

   // One request type per cycle on the register bus
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(csr_rd_i && csr_wr_i));

endmodule

`default_nettype wire

// File: verilog/comp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module comp_unit (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       in_valid_i,
   input  wire comp_stream_pkg::word_t     in_data_i,
   input  wire comp_stream_pkg::rem_t      in_rem_i,
   input  wire logic                       in_last_i,
   output logic                            in_ready_o,
   output logic                            out_valid_o,
   output comp_stream_pkg::word_t          out_data_o,
   output logic                            out_last_o,
   input  wire logic                       out_ready_i,
   input  wire logic                       csr_rd_i,
   input  wire logic                       csr_wr_i,
   input  wire comp_csr_pkg::csr_addr_t    csr_addr_i,
   input  wire comp_csr_pkg::csr_data_t    csr_wdata_i,
   output comp_csr_pkg::csr_data_t         csr_rdata_o,
   output logic                            csr_ack_o
);
   import comp_stream_pkg::*;

   logic      push_valid, push_last, push_ready;
   word_t     push_data;
   rem_t      push_rem;
   logic      pop_valid, pop_last, pop_ready;
   word_t     pop_data;
   rem_t      pop_rem;
   logic      info_valid, info_ready;
   flags_t    info_flags;
   len_t      info_len;
   task_idx_t info_task;
   logic      soft_rst;
   logic      pkt_done;
   len_t      pkt_bytes;

   pkt_ingress u_ingress (
      .clk, .rst_n, .soft_rst_i(soft_rst),
      .in_valid_i, .in_data_i, .in_rem_i, .in_last_i, .in_ready_o,
      .push_valid_o(push_valid), .push_data_o(push_data), .push_rem_o(push_rem),
      .push_last_o(push_last), .push_ready_i(push_ready),
      .info_valid_o(info_valid), .info_flags_o(info_flags), .info_len_o(info_len),
      .info_task_o(info_task), .info_ready_i(info_ready)
   );

   payload_fifo u_fifo (
      .clk, .rst_n, .soft_rst_i(soft_rst),
      .push_valid_i(push_valid), .push_data_i(push_data), .push_rem_i(push_rem),
      .push_last_i(push_last), .push_ready_o(push_ready),
      .pop_valid_o(pop_valid), .pop_data_o(pop_data), .pop_rem_o(pop_rem),
      .pop_last_o(pop_last), .pop_ready_i(pop_ready)
   );

   pkt_egress u_egress (
      .clk, .rst_n, .soft_rst_i(soft_rst),
      .info_valid_i(info_valid), .info_flags_i(info_flags), .info_len_i(info_len),
      .info_task_i(info_task), .info_ready_o(info_ready),
      .pop_valid_i(pop_valid), .pop_data_i(pop_data), .pop_rem_i(pop_rem),
      .pop_last_i(pop_last), .pop_ready_o(pop_ready),
      .out_valid_o, .out_data_o, .out_last_o, .out_ready_i,
      .pkt_done_o(pkt_done), .pkt_bytes_o(pkt_bytes)
   );

   comp_csr u_csr (
      .clk, .rst_n,
      .csr_rd_i, .csr_wr_i, .csr_addr_i, .csr_wdata_i, .csr_rdata_o, .csr_ack_o,
      .pkt_done_i(pkt_done), .pkt_bytes_i(pkt_bytes),
      .soft_rst_o(soft_rst)
   );

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int HALF_PERIOD = 2,  // 4 ns period
   parameter int RST_CYCLES  = 2
) (
   output logic clk_o,
   output logic rst_n_o
);
   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: tb/tb_comp_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "comp_defines.svh"

module tb_comp_unit;
   import comp_stream_pkg::*;
   import comp_csr_pkg::*;

   localparam int NROWS    = 7;
   localparam int SRST_ROW = 4;  // Soft reset goes in before this row

   typedef struct packed {
      flags_t    flags;
      task_idx_t task_idx;
      len_t      decl_len;
      int        n_words;
      rem_t      rem;
      logic      bp;          // Random out_ready
   } row_t;

   logic      clk, rst_n;
   logic      in_valid, in_last, in_ready;
   word_t     in_data;
   rem_t      in_rem;
   logic      out_valid, out_last, out_ready;
   word_t     out_data;
   logic      csr_rd, csr_wr, csr_ack;
   csr_addr_t csr_addr;
   csr_data_t csr_wdata, csr_rdata;

   row_t  rows [NROWS];
   word_t exp_data [$];
   logic  exp_last [$];
   int    errors = 0;
   int    cycles = 0;
   int    limit;
   int    pkt_cnt_exp;
   len_t  last_len_exp;

   clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   comp_unit i_comp_unit (
      .clk, .rst_n,
      .in_valid_i(in_valid), .in_data_i(in_data), .in_rem_i(in_rem), .in_last_i(in_last),
      .in_ready_o(in_ready),
      .out_valid_o(out_valid), .out_data_o(out_data), .out_last_o(out_last),
      .out_ready_i(out_ready),
      .csr_rd_i(csr_rd), .csr_wr_i(csr_wr), .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata),
      .csr_rdata_o(csr_rdata), .csr_ack_o(csr_ack)
   );

   // Bytes in use in the final payload word
   function automatic int valid_bytes(rem_t r);
      if (r == 4'h1) return 3;
      if (r == 4'h3) return 2;
      if (r == 4'h7) return 1;
      return 4;
   endfunction

   task automatic drive_input(word_t words [$], rem_t last_rem);
      int i;
      i = 0;
      while (i < words.size()) begin
         in_valid <= 1'b1;
         in_data  <= words[i];
         in_last  <= (i == words.size() - 1);
         in_rem   <= (i == words.size() - 1) ? last_rem : 4'h0;
         @(posedge clk);
         if (in_ready) i++;
      end
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic collect_output(logic bp);
      out_ready <= 1'b1;
      while (exp_data.size() > 0) begin
         @(posedge clk);
         if (out_valid && out_ready) begin
            if (out_data !== exp_data[0]) begin
               errors++;
               $display("ERROR t=%0t out_data_o expected %h got %h", $time, exp_data[0], out_data);
            end
            if (out_last !== exp_last[0]) begin
               errors++;
               $display("ERROR t=%0t out_last_o expected %b got %b", $time, exp_last[0], out_last);
            end
            void'(exp_data.pop_front());
            void'(exp_last.pop_front());
         end
         out_ready <= bp ? 1'($urandom % 2) : 1'b1;
      end
   endtask

   task automatic run_row(row_t row);
      word_t words [$];
      word_t w;
      int    nb;
      len_t  total;
      total = '0;
      for (int i = 0; i < `COMP_HDR_WORDS; i++) begin
         w = $urandom;  // Unused header bits stay random
         if (i == `COMP_HDR_FLAG_IDX) w[31:29] = row.flags;
         if (i == `COMP_HDR_LEN_IDX) w = row.decl_len;
         if (i == `COMP_HDR_TASK_IDX) w[9:0] = row.task_idx;
         words.push_back(w);
      end
      for (int i = 0; i < row.n_words; i++) begin
         w = $urandom;
         words.push_back(w);
         nb = (i == row.n_words - 1) ? valid_bytes(row.rem) : 4;
         exp_data.push_back(w & (32'hffff_ffff << (8 * (4 - nb))));
         exp_last.push_back(1'b0);
         total += len_t'(nb);
      end
      exp_data.push_back({row.flags, total == row.decl_len, 28'h0});
      exp_data.push_back(total);
      exp_data.push_back({22'h0, row.task_idx});
      exp_data.push_back(32'h0);
      exp_last.push_back(1'b0);
      exp_last.push_back(1'b0);
      exp_last.push_back(1'b0);
      exp_last.push_back(1'b1);
      fork
         drive_input(words, row.rem);
         collect_output(row.bp);
      join
      pkt_cnt_exp++;
      last_len_exp = total;
   endtask

   task automatic csr_access(logic wr, csr_addr_t addr, csr_data_t data, string name);
      csr_rd    <= !wr;
      csr_wr    <= wr;
      csr_addr  <= addr;
      csr_wdata <= wr ? data : 32'h0;
      @(posedge clk);
      csr_rd <= 1'b0;
      csr_wr <= 1'b0;
      @(posedge clk);  // Ack and read data are due now
      if (csr_ack !== 1'b1) begin
         errors++;
         $display("ERROR t=%0t csr_ack_o expected 1 got %b", $time, csr_ack);
      end
      if (!wr && csr_rdata !== data) begin
         errors++;
         $display("ERROR t=%0t csr_rdata_o (%s) expected %h got %h", $time, name, data, csr_rdata);
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the packet stream stopped moving", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      void'($urandom(87));
      in_valid  = 1'b0;
      in_data   = '0;
      in_rem    = '0;
      in_last   = 1'b0;
      out_ready = 1'b1;
      csr_rd    = 1'b0;
      csr_wr    = 1'b0;
      csr_addr  = '0;
      csr_wdata = '0;
      pkt_cnt_exp  = 0;
      last_len_exp = '0;

      //          flags   task     decl len n  rem   bp
      rows[0] = '{3'b101, 10'h12a, 32'd12, 3, 4'h0, 1'b0};
      rows[1] = '{3'b010, 10'h3ff, 32'd19, 5, 4'h1, 1'b0};
      rows[2] = '{3'b111, 10'h001, 32'd1, 1, 4'h7, 1'b1};
      rows[3] = '{3'b000, 10'h200, 32'd30, 6, 4'h3, 1'b1};  // Length mismatch
      rows[4] = '{3'b100, 10'h055, 32'd36, 9, 4'h0, 1'b1};
      rows[5] = '{3'b011, 10'h2c3, 32'd8, 2, 4'h1, 1'b0};   // Length mismatch
      rows[6] = '{3'b110, 10'h0f0, 32'd45, 12, 4'h7, 1'b1};

      limit = 200;
      for (int r = 0; r < NROWS; r++) limit += 8 * (`COMP_HDR_WORDS + `COMP_TRL_WORDS
                                                   + 2 * rows[r].n_words);

      @(posedge rst_n);
      @(posedge clk);
      if (in_ready !== 1'b1 || out_valid !== 1'b0 || csr_ack !== 1'b0) begin
         errors++;
         $display("Outputs after reset are wrong, in_ready_o should be 1, the others 0");
      end

      for (int r = 0; r < NROWS; r++) begin
         if (r == SRST_ROW) begin
            csr_access(1'b1, CSR_CTRL, 32'h1, "CTRL");
            pkt_cnt_exp  = 0;
            last_len_exp = '0;
            csr_access(1'b0, CSR_PKT_CNT, 32'h0, "PKT_CNT");
            csr_access(1'b0, CSR_LAST_LEN, 32'h0, "LAST_LEN");
         end
         run_row(rows[r]);
         csr_access(1'b0, CSR_ID, 32'h1006_0402, "ID");
         csr_access(1'b0, CSR_PKT_CNT, csr_data_t'(pkt_cnt_exp), "PKT_CNT");
         csr_access(1'b0, CSR_LAST_LEN, last_len_exp, "LAST_LEN");
      end

      $display("Run complete, %0d rows, %0d errors", NROWS, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/comp_stream_pkg.sv
common/comp_csr_pkg.sv
engine/pkt_ingress.sv
engine/payload_fifo.sv
engine/pkt_egress.sv
verilog/comp_csr.sv
verilog/comp_unit.sv
tb/clk_gen.sv
tb/tb_comp_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_comp_unit
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
